// File: verilog/rix_bus_pkg.sv
// Memory bus package with word and address types, request struct and tag queue sizing
package rix_bus_pkg;

    // Memory words and stream words share one width
    localparam int data_width = 32;
    localparam int addr_width = 20;

    typedef logic [data_width-1:0] word_t;

    // Word address, not byte address
    typedef logic [addr_width-1:0] mem_addr_t;

    // Single-beat request, wdata is ignored for reads
    typedef struct packed {
        logic      write;
        mem_addr_t addr;
        word_t     wdata;
    } mem_req_t;

    // Requester tag kept per read in flight
    typedef logic peer_t;

    localparam peer_t peer_cmd = 1'b0;
    localparam peer_t peer_tex = 1'b1;

    // Reads in flight across both peers
    localparam int tag_depth     = 4;
    localparam int tag_ptr_width = $clog2(tag_depth);

endpackage

// File: verilog/rix_cmd_pkg.sv
// Command protocol package with opcodes, header field positions and decoder states
package rix_cmd_pkg;

    // Header opcode in the top nibble
    typedef enum logic [3:0] {
        op_nop   = 4'd0,
        op_write = 4'd1,
        op_read  = 4'd2,
        op_swap  = 4'd3
    } opcode_t;

    // Payload or read word count
    typedef logic [7:0] cmd_count_t;

    // Header layout, address sits in the low bits below count_lsb
    localparam int op_lsb    = 28;
    localparam int count_lsb = 20;

    // SWAP reuses the top count bit as the vsync request
    localparam int vsync_bit = 27;

    typedef enum logic [1:0] {
        st_header,
        st_write,
        st_read,
        st_swap
    } dec_state_t;

endpackage

// File: verilog/cmd_decoder.sv
// Command decoder turning the command stream into memory requests, responses and swaps
module cmd_decoder
    import rix_bus_pkg::*;
    import rix_cmd_pkg::*;
(
    input  logic     aclk,
    input  logic     arst_n,

    input  logic     s_cmd_valid,
    output logic     s_cmd_ready,
    input  logic     s_cmd_last,
    input  word_t    s_cmd_data,

    output logic     m_resp_valid,
    input  logic     m_resp_ready,
    output logic     m_resp_last,
    output word_t    m_resp_data,

    output mem_req_t cmd_req,
    output logic     cmd_req_valid,
    input  logic     cmd_req_ready,
    input  logic     cmd_rsp_valid,
    input  word_t    rsp_data,

    output logic     swap_start,
    output mem_addr_t swap_addr,
    output logic     swap_vsync,
    input  logic     swap_done
);
    dec_state_t state;
    word_t      hdr;
    cmd_count_t idx;
    logic       started;
    logic       outstanding;
    logic       resp_valid_q;
    logic       resp_last_q;
    word_t      resp_data_q;
    logic       swap_start_q;

    opcode_t    in_op;
    cmd_count_t in_count;
    cmd_count_t hdr_count;
    mem_addr_t  hdr_addr;
    logic       hdr_accept;
    logic       wr_accept;
    logic       rd_issue;
    logic       resp_pop;
    logic       final_word;

    // Fields of the incoming header word
    assign in_op    = opcode_t'(s_cmd_data[op_lsb +: $bits(opcode_t)]);
    assign in_count = s_cmd_data[count_lsb +: $bits(cmd_count_t)];

    // Fields of the latched header
    assign hdr_count = hdr[count_lsb +: $bits(cmd_count_t)];
    assign hdr_addr  = hdr[$bits(mem_addr_t)-1:0];

    // Count 0 still yields one word, so index 0 is then the final one
    assign final_word = ({1'b0, idx} + 9'd1) >= {1'b0, hdr_count};

    assign hdr_accept = (state == st_header) && started && s_cmd_valid;
    assign wr_accept  = (state == st_write) && s_cmd_valid && cmd_req_ready;
    assign rd_issue   = (state == st_read) && cmd_req_valid && cmd_req_ready;
    assign resp_pop   = resp_valid_q && m_resp_ready;

    // Payload words only move when the arbiter takes them
    assign s_cmd_ready = ((state == st_header) && started)
                      || ((state == st_write) && cmd_req_ready);

    // One read at a time, only into an empty output buffer
    assign cmd_req_valid = ((state == st_write) && s_cmd_valid)
                        || ((state == st_read) && !outstanding && !resp_valid_q);

    always_comb
    begin
        cmd_req.write = (state == st_write);
        cmd_req.addr  = hdr_addr + mem_addr_t'(idx);
        cmd_req.wdata = s_cmd_data;
    end

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state        <= st_header;
            started      <= 1'b0;
            outstanding  <= 1'b0;
            resp_valid_q <= 1'b0;
            swap_start_q <= 1'b0;
            idx          <= '0;
        end
        else
        begin
            // Command stream stays closed for the first cycle out of reset
            started      <= 1'b1;
            swap_start_q <= hdr_accept && (in_op == op_swap);

            if (rd_issue)
                outstanding <= 1'b1;
            else if (cmd_rsp_valid)
                outstanding <= 1'b0;

            if (cmd_rsp_valid || swap_done)
                resp_valid_q <= 1'b1;
            else if (resp_pop)
                resp_valid_q <= 1'b0;

            if (hdr_accept)
                idx <= '0;
            else if (wr_accept || cmd_rsp_valid)
                idx <= idx + 8'd1;

            case (state)
                st_header:
                begin
                    if (hdr_accept)
                    begin
                        case (in_op)
                            op_write: state <= (in_count != '0) ? st_write : st_header;
                            op_read:  state <= st_read;
                            op_swap:  state <= st_swap;
                            default:  state <= st_header;
                        endcase
                    end
                end
                st_write:
                begin
                    // An early last also ends the payload
                    if (wr_accept && (final_word || s_cmd_last))
                        state <= st_header;
                end
                st_read, st_swap:
                begin
                    if (resp_pop && resp_last_q)
                        state <= st_header;
                end
                default:
                    state <= st_header;
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (hdr_accept)
            hdr <= s_cmd_data;

        if (cmd_rsp_valid)
        begin
            resp_data_q <= rsp_data;
            resp_last_q <= final_word;
        end
        else if (swap_done)
        begin
            // Swap is acknowledged by echoing its header
            resp_data_q <= hdr;
            resp_last_q <= 1'b1;
        end
    end

    assign m_resp_valid = resp_valid_q;
    assign m_resp_last  = resp_last_q;
    assign m_resp_data  = resp_data_q;

    assign swap_start = swap_start_q;
    assign swap_addr  = hdr_addr;
    assign swap_vsync = hdr[vsync_bit];

    // Held response must not change under back-pressure
    a_resp_stable: assert property (@(posedge aclk) disable iff (!arst_n)
        m_resp_valid && !m_resp_ready |=> m_resp_valid && $stable(m_resp_data));

endmodule

// File: verilog/mem_arbiter.sv
// Round-robin arbiter sharing the memory port between command and texture peers
module mem_arbiter
    import rix_bus_pkg::*;
(
    input  logic      aclk,
    input  logic      arst_n,

    input  mem_req_t  cmd_req,
    input  logic      cmd_req_valid,
    output logic      cmd_req_ready,
    output logic      cmd_rsp_valid,

    input  logic      tex_req_valid,
    input  mem_addr_t tex_addr,
    output logic      tex_req_ready,
    output logic      tex_rsp_valid,

    output mem_req_t  mem_req,
    output logic      mem_req_valid,
    input  logic      mem_req_ready,
    input  logic      mem_rsp_valid
);
    peer_t                    last_grant;
    peer_t                    tag_fifo [tag_depth];
    logic [tag_ptr_width-1:0] wr_ptr;
    logic [tag_ptr_width-1:0] rd_ptr;
    logic [tag_ptr_width:0]   fill;

    mem_req_t tex_req;
    peer_t    head;
    logic     full;
    logic     empty;
    logic     pick_tex;
    logic     accept;
    logic     push;
    logic     pop;

    // Texture peer only ever reads
    assign tex_req.write = 1'b0;
    assign tex_req.addr  = tex_addr;
    assign tex_req.wdata = '0;

    assign full  = fill == (tag_ptr_width + 1)'(tag_depth);
    assign empty = fill == '0;

    // On contention the peer not granted last wins
    assign pick_tex = tex_req_valid && (!cmd_req_valid || last_grant == peer_cmd);

    assign mem_req       = pick_tex ? tex_req : cmd_req;
    assign mem_req_valid = (cmd_req_valid || tex_req_valid) && !full;
    assign accept        = mem_req_valid && mem_req_ready;

    assign cmd_req_ready = accept && !pick_tex;
    assign tex_req_ready = accept && pick_tex;

    // Only reads come back, so only reads take a tag
    assign push = accept && !mem_req.write;
    assign pop  = mem_rsp_valid && !empty;
    assign head = tag_fifo[rd_ptr];

    assign cmd_rsp_valid = pop && (head == peer_cmd);
    assign tex_rsp_valid = pop && (head == peer_tex);

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            last_grant <= peer_tex;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
        end
        else
        begin
            if (accept)
                last_grant <= pick_tex ? peer_tex : peer_cmd;
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                fill <= fill + 1'b1;
            else if (pop && !push)
                fill <= fill - 1'b1;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (push)
            tag_fifo[wr_ptr] <= pick_tex ? peer_tex : peer_cmd;
    end

    a_tag_bound: assert property (@(posedge aclk) disable iff (!arst_n)
        fill <= (tag_ptr_width + 1)'(tag_depth));

    // Memory must only answer reads that were issued
    a_rsp_expected: assert property (@(posedge aclk) disable iff (!arst_n)
        mem_rsp_valid |-> !empty);

endmodule

// File: verilog/fb_swap_ctrl.sv
// Framebuffer swap control holding a swap request until the display confirms it
module fb_swap_ctrl
    import rix_bus_pkg::*;
(
    input  logic      aclk,
    input  logic      arst_n,
    input  logic      swap_start,
    input  mem_addr_t swap_addr,
    input  logic      swap_vsync,
    output logic      swap_fb,
    output logic      swap_fb_enable_vsync,
    output mem_addr_t fb_addr,
    input  logic      fb_swapped,
    output logic      swap_done
);
    logic      pending;
    logic      vsync_q;
    mem_addr_t addr_q;

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
            pending <= 1'b0;
        else if (swap_start)
            pending <= 1'b1;
        else if (fb_swapped)
            pending <= 1'b0;
    end

    // Buffer address and vsync stay on the outputs after the swap
    always_ff @(posedge aclk)
    begin
        if (swap_start)
        begin
            addr_q  <= swap_addr;
            vsync_q <= swap_vsync;
        end
    end

    assign swap_fb              = pending;
    assign swap_fb_enable_vsync = vsync_q;
    assign fb_addr              = addr_q;
    assign swap_done            = pending && fb_swapped;

    // Decoder must wait for the previous swap to finish
    a_no_restart: assert property (@(posedge aclk) disable iff (!arst_n)
        swap_start |-> !pending);

endmodule

// File: verilog/rix_mem_if.sv
// Graphics memory interface top with command decoder, swap control and memory arbiter
module rix_mem_if
    import rix_bus_pkg::*;
(
    input  logic      aclk,
    input  logic      arst_n,

    input  logic      s_cmd_valid,
    output logic      s_cmd_ready,
    input  logic      s_cmd_last,
    input  word_t     s_cmd_data,

    output logic      m_resp_valid,
    input  logic      m_resp_ready,
    output logic      m_resp_last,
    output word_t     m_resp_data,

    input  logic      tex_req_valid,
    output logic      tex_req_ready,
    input  mem_addr_t tex_addr,
    output logic      tex_rsp_valid,
    output word_t     tex_rsp_data,

    output mem_req_t  mem_req,
    output logic      mem_req_valid,
    input  logic      mem_req_ready,
    input  logic      mem_rsp_valid,
    input  word_t     mem_rsp_data,

    output logic      swap_fb,
    output logic      swap_fb_enable_vsync,
    output mem_addr_t fb_addr,
    input  logic      fb_swapped
);
    mem_req_t  cmd_req;
    logic      cmd_req_valid;
    logic      cmd_req_ready;
    logic      cmd_rsp_valid;
    logic      swap_start;
    mem_addr_t swap_addr;
    logic      swap_vsync;
    logic      swap_done;

    // Read data fans out to both peers, the arbiter qualifies it
    assign tex_rsp_data = mem_rsp_data;

    cmd_decoder u_cmd_decoder (
        .aclk          (aclk),
        .arst_n        (arst_n),
        .s_cmd_valid   (s_cmd_valid),
        .s_cmd_ready   (s_cmd_ready),
        .s_cmd_last    (s_cmd_last),
        .s_cmd_data    (s_cmd_data),
        .m_resp_valid  (m_resp_valid),
        .m_resp_ready  (m_resp_ready),
        .m_resp_last   (m_resp_last),
        .m_resp_data   (m_resp_data),
        .cmd_req       (cmd_req),
        .cmd_req_valid (cmd_req_valid),
        .cmd_req_ready (cmd_req_ready),
        .cmd_rsp_valid (cmd_rsp_valid),
        .rsp_data      (mem_rsp_data),
        .swap_start    (swap_start),
        .swap_addr     (swap_addr),
        .swap_vsync    (swap_vsync),
        .swap_done     (swap_done)
    );

    fb_swap_ctrl u_fb_swap_ctrl (
        .aclk                 (aclk),
        .arst_n               (arst_n),
        .swap_start           (swap_start),
        .swap_addr            (swap_addr),
        .swap_vsync           (swap_vsync),
        .swap_fb              (swap_fb),
        .swap_fb_enable_vsync (swap_fb_enable_vsync),
        .fb_addr              (fb_addr),
        .fb_swapped           (fb_swapped),
        .swap_done            (swap_done)
    );

    mem_arbiter u_mem_arbiter (
        .aclk          (aclk),
        .arst_n        (arst_n),
        .cmd_req       (cmd_req),
        .cmd_req_valid (cmd_req_valid),
        .cmd_req_ready (cmd_req_ready),
        .cmd_rsp_valid (cmd_rsp_valid),
        .tex_req_valid (tex_req_valid),
        .tex_addr      (tex_addr),
        .tex_req_ready (tex_req_ready),
        .tex_rsp_valid (tex_rsp_valid),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid)
    );

endmodule

// File: test/tb_mem_model.sv
// Memory model with random request ready and in-order read data after a random latency
module tb_mem_model
    import rix_bus_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  mem_req_t   mem_req,
    input  logic       mem_req_valid,
    input  logic       ready_next,
    input  logic [2:0] latency,
    output logic       mem_req_ready,
    output logic       mem_rsp_valid,
    output word_t      mem_rsp_data
);
    word_t mem [mem_addr_t];
    word_t rsp_data_q [$];
    int    rsp_due_q [$];
    int    cycle;
    int    last_due;
    int    due;
    logic  run;
    logic  ready_q;

    initial
    begin
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        cycle         = 0;
        last_due      = 0;
    end

    always @(posedge clk)
    begin
        cycle   = cycle + 1;
        run     = arst_n;
        ready_q = ready_next;
        if (!run)
        begin
            rsp_data_q.delete();
            rsp_due_q.delete();
        end
        else if (mem_req_valid && mem_req_ready)
        begin
            if (mem_req.write)
                mem[mem_req.addr] = mem_req.wdata;
            else
            begin
                // Reads leave in request order and at most one per cycle
                due = cycle + int'(latency);
                if (due <= last_due)
                    due = last_due + 1;
                last_due = due;
                rsp_due_q.push_back(due);
                rsp_data_q.push_back(mem.exists(mem_req.addr) ? mem[mem_req.addr] : 'x);
            end
        end
        #10;
        mem_req_ready = run && ready_q;
        mem_rsp_valid = 1'b0;
        if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle)
        begin
            mem_rsp_valid = 1'b1;
            mem_rsp_data  = rsp_data_q.pop_front();
            void'(rsp_due_q.pop_front());
        end
    end

endmodule

// File: test/tb_rix_mem_if.sv
// Testbench for the graphics memory interface with command, texture and swap traffic
module tb_rix_mem_if
    import rix_bus_pkg::*;
    import rix_cmd_pkg::*;
();
    localparam int        clk_period  = 100;
    localparam int        drive_delay = 10;
    localparam int        n_pairs     = 10;
    localparam int        n_cmds      = 2 + 2 * n_pairs + n_pairs / 4;
    localparam int        tex_total   = 48;
    localparam int        tex_words   = 16;
    localparam mem_addr_t tex_base    = 20'h00100;
    localparam mem_addr_t cmd_base    = 20'h00200;

    typedef struct packed {
        logic  last;
        word_t data;
    } cmd_word_t;

    // Expected response word with chk low where the data is undefined
    typedef struct packed {
        logic  is_swap;
        logic  chk;
        logic  last;
        word_t data;
    } resp_exp_t;

    typedef struct packed {
        logic      vsync;
        mem_addr_t addr;
    } swap_exp_t;

    logic      aclk = 1'b0;
    logic      arst_n;
    logic      s_cmd_valid;
    logic      s_cmd_ready;
    logic      s_cmd_last;
    word_t     s_cmd_data;
    logic      m_resp_valid;
    logic      m_resp_ready;
    logic      m_resp_last;
    word_t     m_resp_data;
    logic      tex_req_valid;
    logic      tex_req_ready;
    mem_addr_t tex_addr;
    logic      tex_rsp_valid;
    word_t     tex_rsp_data;
    mem_req_t  mem_req;
    logic      mem_req_valid;
    logic      mem_req_ready;
    logic      mem_rsp_valid;
    word_t     mem_rsp_data;
    logic      swap_fb;
    logic      swap_fb_enable_vsync;
    mem_addr_t fb_addr;
    logic      fb_swapped;
    logic      mem_ready_next;
    logic [2:0] mem_latency;

    logic [31:0] lfsr;
    word_t       shadow [mem_addr_t];
    cmd_word_t   cmd_q [$];
    resp_exp_t   resp_q [$];
    swap_exp_t   swap_q [$];
    word_t       tex_q [$];
    int          error_count;
    int          check_count;
    int          words_sent;
    int          tex_issued;
    int          swap_wait;
    logic        tex_fire;
    logic        swap_seen;
    logic        swap_confirmed;
    logic        run;

    rix_mem_if dut0 (.*);

    tb_mem_model mem0 (
        .clk           (aclk),
        .arst_n        (arst_n),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .ready_next    (mem_ready_next),
        .latency       (mem_latency),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

    always #(clk_period / 2) aclk = ~aclk;

    // Fibonacci LFSR with taps 32, 22, 2 and 1 stepped once per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("[ERROR] %s: got %h, expected %h at time %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("%s at time %0t", what, $time);
    endtask

    function automatic word_t make_header(input opcode_t op, input cmd_count_t count,
                                          input mem_addr_t addr);
        word_t h;
        h = '0;
        h[op_lsb +: 4]    = op;
        h[count_lsb +: 8] = count;
        h[19:0]           = addr;
        return h;
    endfunction

    task automatic add_write(input mem_addr_t addr, input cmd_count_t count);
        word_t w;
        cmd_q.push_back({1'b0, make_header(op_write, count, addr)});
        for (int k = 0; k < int'(count); k++)
        begin
            w = random_bits(32);
            shadow[addr + mem_addr_t'(k)] = w;
            cmd_q.push_back({k == int'(count) - 1, w});
        end
    endtask

    task automatic add_read(input mem_addr_t addr, input cmd_count_t count);
        cmd_q.push_back({1'b1, make_header(op_read, count, addr)});
        // Count 0 still answers one word whose data is undefined
        if (count == '0)
            resp_q.push_back({1'b0, 1'b0, 1'b1, 32'h0});
        for (int k = 0; k < int'(count); k++)
            resp_q.push_back({1'b0, 1'b1, k == int'(count) - 1, shadow[addr + mem_addr_t'(k)]});
    endtask

    task automatic add_swap(input mem_addr_t addr, input logic vsync);
        word_t h;
        h            = make_header(op_swap, '0, addr);
        h[vsync_bit] = vsync;
        cmd_q.push_back({1'b1, h});
        swap_q.push_back({vsync, addr});
        resp_q.push_back({1'b1, 1'b1, 1'b1, h});
    endtask

    // Texture region is filled once and command traffic stays in its own region
    task automatic build_program();
        cmd_count_t count;
        mem_addr_t  offset;
        add_write(tex_base, cmd_count_t'(tex_words));
        for (int i = 0; i < n_pairs; i++)
        begin
            count  = cmd_count_t'(random_bits(4)) + 8'd1;
            offset = mem_addr_t'(random_bits(4));
            add_write(cmd_base + offset, count);
            add_read(cmd_base + offset, count);
            if (i % 4 == 3)
                add_swap(mem_addr_t'(random_bits(20)), random_bits(1) != 0);
        end
        add_read(cmd_base, '0);
    endtask

    task automatic check_reset_state();
        check_value("s_cmd_ready", s_cmd_ready, 0);
        check_value("m_resp_valid", m_resp_valid, 0);
        check_value("swap_fb", swap_fb, 0);
        check_value("tex_rsp_valid", tex_rsp_valid, 0);
        check_value("mem_req_valid", mem_req_valid, 0);
        check_value("tex_req_ready", tex_req_ready, 0);
    endtask

    task automatic sample_outputs();
        resp_exp_t exp;
        swap_exp_t sw;
        if (s_cmd_valid && s_cmd_ready)
        begin
            void'(cmd_q.pop_front());
            words_sent++;
        end
        if (m_resp_valid && m_resp_ready)
        begin
            if (resp_q.size() == 0)
                report_failure("Response word arrived with no response expected");
            else
            begin
                exp = resp_q.pop_front();
                if (exp.is_swap && !swap_confirmed)
                    report_failure("Swap response arrived before the swap was confirmed");
                if (exp.is_swap)
                    swap_confirmed = 1'b0;
                if (exp.chk)
                    check_value("m_resp_data", m_resp_data, exp.data);
                check_value("m_resp_last", m_resp_last, exp.last);
            end
        end
        if (tex_req_valid && tex_req_ready)
        begin
            tex_q.push_back(shadow[tex_addr]);
            tex_fire = 1'b1;
        end
        if (tex_rsp_valid)
        begin
            if (tex_q.size() == 0)
                report_failure("Texture response arrived with no texture read pending");
            else
                check_value("tex_rsp_data", tex_rsp_data, tex_q.pop_front());
        end
        if (swap_fb && !fb_swapped && !swap_seen)
        begin
            swap_seen = 1'b1;
            swap_wait = int'(random_bits(3)) + 2;
            if (swap_q.size() == 0)
                report_failure("swap_fb went high with no SWAP command sent");
            else
            begin
                sw = swap_q.pop_front();
                check_value("fb_addr", fb_addr, sw.addr);
                check_value("swap_fb_enable_vsync", swap_fb_enable_vsync, sw.vsync);
            end
        end
    endtask

    task automatic drive_inputs();
        cmd_word_t w;
        m_resp_ready   = random_bits(2) != 0;
        mem_ready_next = random_bits(2) != 0;
        mem_latency    = 3'(random_bits(3) % 6) + 3'd1;
        s_cmd_valid    = cmd_q.size() > 0;
        if (cmd_q.size() > 0)
        begin
            w          = cmd_q[0];
            s_cmd_last = w.last;
            s_cmd_data = w.data;
        end
        if (tex_fire)
        begin
            tex_req_valid = 1'b0;
            tex_fire      = 1'b0;
        end
        // Texture reads start once the texture region is written
        if (!tex_req_valid && words_sent > tex_words && tex_issued < tex_total
            && random_bits(1) != 0)
        begin
            tex_req_valid = 1'b1;
            tex_addr      = tex_base + mem_addr_t'(random_bits(4));
            tex_issued++;
        end
        if (fb_swapped)
        begin
            fb_swapped     = 1'b0;
            swap_seen      = 1'b0;
            swap_confirmed = 1'b1;
        end
        else if (swap_seen)
        begin
            if (swap_wait == 0)
                fb_swapped = 1'b1;
            else
                swap_wait--;
        end
    endtask

    function automatic logic all_done();
        return cmd_q.size() == 0 && resp_q.size() == 0 && tex_q.size() == 0
            && swap_q.size() == 0 && tex_issued == tex_total && !tex_req_valid;
    endfunction

    always @(posedge aclk)
    begin
        run = arst_n;
        if (run)
            sample_outputs();
        #drive_delay;
        if (run)
            drive_inputs();
    end

    initial
    begin
        arst_n         = 1'b0;
        s_cmd_valid    = 1'b0;
        s_cmd_last     = 1'b0;
        s_cmd_data     = '0;
        m_resp_ready   = 1'b0;
        tex_req_valid  = 1'b0;
        tex_addr       = '0;
        fb_swapped     = 1'b0;
        mem_ready_next = 1'b0;
        mem_latency    = 3'd1;
        lfsr           = 32'h9884;
        error_count    = 0;
        check_count    = 0;
        words_sent     = 0;
        tex_issued     = 0;
        swap_wait      = 0;
        tex_fire       = 1'b0;
        swap_seen      = 1'b0;
        swap_confirmed = 1'b0;
        build_program();
        repeat (3) @(posedge aclk);
        #drive_delay;
        check_reset_state();
        arst_n = 1'b1;
        while (!all_done())
            @(posedge aclk);
        // Idle a little so stray responses are still caught
        repeat (20) @(posedge aclk);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    initial
    begin
        #(n_cmds * 200 * clk_period);
        error_count++;
        $display("Watchdog expired after %0d cycles because the traffic stalled",
                 n_cmds * 200);
        $display("Still pending: %0d command words, %0d responses, %0d texture reads",
                 cmd_q.size(), resp_q.size(), tex_q.size());
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: compile.f
verilog/rix_bus_pkg.sv
verilog/rix_cmd_pkg.sv
verilog/cmd_decoder.sv
verilog/mem_arbiter.sv
verilog/fb_swap_ctrl.sv
verilog/rix_mem_if.sv
test/tb_mem_model.sv
test/tb_rix_mem_if.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_rix_mem_if \
    -f compile.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^TESTBENCH PASSED$'; then
    exit 0
fi
exit 1
